/* project.f */
+incdir+verilog
+incdir+verification
verilog/host_pkg.sv
verilog/audio_pkg.sv
verilog/host_state_if.sv
verilog/user_io_spi.sv
verilog/ps2_keyboard.sv
verilog/control_mapper.sv
verilog/audio_sample_dispatch.sv
verilog/sigma_delta_dac.sv
verilog/bomber_shell_top.sv
verification/shell_tb.sv

/* verification/shell_tb_drivers.svh */
// Testbench bus drivers
`ifndef SHELL_TB_DRIVERS_SVH
`define SHELL_TB_DRIVERS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] next_random();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

// returns 1 ns after the last of n rising edges.
task automatic wait_cycles(input int n);
	repeat (n) @(posedge clk_24);
	#1;
endtask

// mode 0 transfer, the id byte is sampled just before each rising sck.
task automatic spi_write(input logic [7:0] cmd, input logic [31:0] data, input int nbytes,
	output logic [7:0] id_seen);
	logic [7:0] tx;
	id_seen = '0;
	spi_ss2 = 1'b0;
	wait_cycles(SPI_HALF);
	for (int b = 0; b <= nbytes; b++) begin
		tx = cmd;
		if (b > 0)
			tx = 8'(data >> (8 * (b - 1)));
		for (int i = 7; i >= 0; i--) begin
			spi_di = tx[i];
			wait_cycles(SPI_HALF);
			if (b == 0)
				id_seen[i] = spi_do;
			spi_sck = 1'b1;
			wait_cycles(SPI_HALF);
			spi_sck = 1'b0;
		end
	end
	wait_cycles(SPI_HALF);
	spi_ss2 = 1'b1;
endtask

// start, eight data bits lsb first, odd parity, stop.
task automatic ps2_send(input logic [7:0] code, input bit good_parity);
	logic [10:0] frame;
	frame = {1'b1, (good_parity ? ~^code : ^code), code, 1'b0};
	for (int i = 0; i < 11; i++) begin
		ps2_kbd_data = frame[i];
		wait_cycles(PS2_HALF / 2);
		ps2_kbd_clk = 1'b0;
		wait_cycles(PS2_HALF);
		ps2_kbd_clk = 1'b1;
		wait_cycles(PS2_HALF / 2);
	end
	ps2_kbd_data = 1'b1;
	wait_cycles(PS2_HALF);
endtask

`endif

/* verification/shell_tb.sv */
// Shell testbench
`timescale 1ns/1ps
`include "shell_settings.svh"

module shell_tb;
	import host_pkg::*;
	import audio_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int SPI_HALF = 6;
	localparam int PS2_HALF = 8;
	localparam int JOY_ROUNDS = 6;
	localparam int AUDIO_ROUNDS = 3;
	localparam int WINDOW = 128;
	localparam int FLUSH = 8 * `SHELL_DAC_PERIOD;
	localparam int HOLD_LIMIT = 4 * `SHELL_RESET_STRETCH;
	// update must pulse within this many cycles after ss2 rises.
	localparam int UPDATE_LIMIT = 4;
	// worst case is a command byte plus four status bytes.
	localparam int SPI_XFER = 2 * SPI_HALF + 5 * 16 * SPI_HALF + 16;
	localparam int PS2_FRAME = 23 * PS2_HALF;
	localparam int RUN_CYCLES = 2 + HOLD_LIMIT + 3 * SPI_XFER + HOLD_LIMIT +
		(2 * JOY_ROUNDS + 3) * SPI_XFER + 10 * PS2_FRAME +
		AUDIO_ROUNDS * (FLUSH + 3 * WINDOW);
	localparam int WATCHDOG_CYCLES = RUN_CYCLES * 3 / 2;

	logic clk_24 = 1'b0;
	logic rst_n;
	logic spi_sck;
	logic spi_ss2;
	logic spi_di;
	logic spi_do;
	logic ps2_kbd_clk;
	logic ps2_kbd_data;
	sample_t audio1;
	sample_t audio2;
	logic audio_l;
	logic audio_r;
	logic game_reset_n;
	logic coin1_n;
	logic coin2_n;
	logic start1_n;
	logic start2_n;
	logic fire1_n;
	logic fire2_n;
	logic slam_n;
	logic test_n;
	logic led;

	int cycle_count;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_errors_base = 0;
	logic [31:0] rng_state = 32'h22e7;

	`include "shell_tb_drivers.svh"

	bomber_shell_top u_dut (
		.clk_24       (clk_24),
		.rst_n        (rst_n),
		.spi_sck      (spi_sck),
		.spi_ss2      (spi_ss2),
		.spi_di       (spi_di),
		.spi_do       (spi_do),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.audio1       (audio1),
		.audio2       (audio2),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.game_reset_n (game_reset_n),
		.coin1_n      (coin1_n),
		.coin2_n      (coin2_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.fire1_n      (fire1_n),
		.fire2_n      (fire2_n),
		.slam_n       (slam_n),
		.test_n       (test_n),
		.led          (led)
	);

	always #(CLK_PERIOD / 2) clk_24 = ~clk_24;

	always @(posedge clk_24) begin
		if (!rst_n)
			cycle_count <= 0;
		else
			cycle_count <= cycle_count + 1;
	end

	// both coin inputs follow the single coin key.
	assert property (@(posedge clk_24) disable iff (!rst_n) coin1_n == coin2_n)
	else begin
		$display("Fail %0t coin2_n expected %b got %b", $time, $sampled(coin1_n),
			$sampled(coin2_n));
		errors++;
	end

	assert property (@(posedge clk_24) disable iff (!rst_n) led == 1'b0)
	else begin
		$display("Fail %0t led expected 0 got %b", $time, $sampled(led));
		errors++;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			$display("Fail %0t %s expected %0h got %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// bit 8 is game_reset_n, then coins, starts, fires, slam and test down to bit 0.
	task automatic check_controls(input logic [8:0] expected);
		string names [9] = '{"test_n", "slam_n", "fire2_n", "fire1_n", "start2_n",
			"start1_n", "coin2_n", "coin1_n", "game_reset_n"};
		logic [8:0] actual;
		actual = {game_reset_n, coin1_n, coin2_n, start1_n, start2_n, fire1_n, fire2_n,
			slam_n, test_n};
		for (int i = 0; i < 9; i++)
			check_value(names[i], expected[i], actual[i]);
	endtask

	task automatic await_update(output bit seen);
		seen = 1'b0;
		for (int i = 0; i < UPDATE_LIMIT && !seen; i++) begin
			@(posedge clk_24);
			#1;
			seen = u_dut.host_state.update;
		end
	endtask

	// controls follow one cycle after the update pulse.
	task automatic settle_host(input bit expect_update);
		bit seen;
		await_update(seen);
		checks++;
		assert (seen == expect_update)
		else begin
			if (expect_update)
				$display("no update pulse after an SPI write at %0t", $time);
			else
				$display("update pulse after an unknown SPI command at %0t", $time);
			errors++;
		end
		wait_cycles(1);
	endtask

	task automatic measure_reset_hold(output int n);
		n = 0;
		while (n < HOLD_LIMIT) begin
			@(posedge clk_24);
			#1;
			n++;
			if (game_reset_n)
				break;
		end
		assert (game_reset_n)
		else begin
			$display("game_reset_n did not rise within %0d cycles", HOLD_LIMIT);
			errors++;
		end
	endtask

	task automatic count_window(output int ones_l, output int ones_r);
		ones_l = 0;
		ones_r = 0;
		repeat (WINDOW) begin
			wait_cycles(1);
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
	endtask

	task automatic start_test();
		test_errors_base = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors > test_errors_base) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	task automatic reset_test();
		int hold;
		start_test();
		check_controls(9'h0ff);
		check_value("audio_l", 0, audio_l);
		check_value("audio_r", 0, audio_r);
		check_value("spi_do", 0, spi_do);
		check_value("sample_valid", 0, u_dut.sample_valid);
		check_value("credit[0]", `SHELL_DAC_CREDITS, u_dut.u_dispatch.credit[0]);
		check_value("credit[1]", `SHELL_DAC_CREDITS, u_dut.u_dispatch.credit[1]);
		rst_n = 1'b1;
		measure_reset_hold(hold);
		check_value("game_reset_n hold", `SHELL_RESET_STRETCH, hold);
		check_controls(9'h1ff);
		finish_test("reset release");
	endtask

	task automatic status_test();
		logic [7:0] id;
		bit seen;
		int hold;
		start_test();
		spi_write(`SHELL_CMD_STATUS, (32'd1 << STATUS_TEST) | (32'd1 << STATUS_SLAM), 4, id);
		check_value("spi_do", `SHELL_CORE_ID, id);
		settle_host(1'b1);
		check_controls(9'h1fc);
		spi_write(`SHELL_CMD_STATUS, 32'd1 << STATUS_MENU_RST, 4, id);
		check_value("spi_do", `SHELL_CORE_ID, id);
		settle_host(1'b1);
		check_controls(9'h0ff);
		spi_write(`SHELL_CMD_STATUS, 32'd0, 4, id);
		await_update(seen);
		assert (seen)
		else begin
			$display("no update pulse after clearing the status word");
			errors++;
		end
		measure_reset_hold(hold);
		check_value("game_reset_n hold", `SHELL_RESET_STRETCH, hold);
		check_controls(9'h1ff);
		finish_test("host status");
	endtask

	task automatic joystick_test();
		logic [31:0] r;
		logic [7:0] id;
		joy_t j0;
		joy_t j1;
		start_test();
		j0 = '0;
		j1 = '0;
		for (int k = 0; k < JOY_ROUNDS; k++) begin
			r = next_random();
			j0 = r[7:0];
			j1 = r[15:8];
			spi_write(`SHELL_CMD_JOY0, {24'd0, j0}, 1, id);
			settle_host(1'b1);
			spi_write(`SHELL_CMD_JOY1, {24'd0, j1}, 1, id);
			settle_host(1'b1);
			check_value("fire1_n", !j0[JOY_FIRE], fire1_n);
			check_value("fire2_n", !j1[JOY_FIRE], fire2_n);
		end
		// inverted fire bits under an unknown command.
		spi_write(8'h55, {24'd0, ~j0}, 1, id);
		settle_host(1'b0);
		check_value("fire1_n", !j0[JOY_FIRE], fire1_n);
		check_value("fire2_n", !j1[JOY_FIRE], fire2_n);
		spi_write(`SHELL_CMD_JOY0, 32'd0, 1, id);
		settle_host(1'b1);
		spi_write(`SHELL_CMD_JOY1, 32'd0, 1, id);
		settle_host(1'b1);
		check_controls(9'h1ff);
		finish_test("joystick");
	endtask

	task automatic keyboard_test();
		start_test();
		// make codes for keys 5, 1 and 2.
		ps2_send(8'h2e, 1'b1);
		check_controls(9'h13f);
		ps2_send(8'h16, 1'b1);
		check_controls(9'h11f);
		ps2_send(8'h1e, 1'b1);
		check_controls(9'h10f);
		ps2_send(8'hf0, 1'b1);
		ps2_send(8'h2e, 1'b1);
		check_controls(9'h1cf);
		ps2_send(8'hf0, 1'b1);
		ps2_send(8'h16, 1'b1);
		check_controls(9'h1ef);
		ps2_send(8'hf0, 1'b1);
		ps2_send(8'h1e, 1'b1);
		check_controls(9'h1ff);
		ps2_send(8'h2e, 1'b0);
		check_controls(9'h1ff);
		finish_test("keyboard");
	endtask

	task automatic audio_test();
		logic [31:0] r;
		sample_t a1;
		sample_t a2;
		int ones_l;
		int ones_r;
		start_test();
		for (int k = 0; k < AUDIO_ROUNDS; k++) begin
			r = next_random();
			a1 = r[6:0];
			a2 = r[14:8];
			audio1 = a1;
			audio2 = a2;
			wait_cycles(FLUSH);
			while (cycle_count % WINDOW != 0)
				wait_cycles(1);
			repeat (2) begin
				count_window(ones_l, ones_r);
				check_value("audio_l ones", a1, ones_l);
				check_value("audio_r ones", a2, ones_r);
			end
		end
		finish_test("audio");
	endtask

	initial begin
		rst_n = 1'b0;
		spi_sck = 1'b0;
		spi_ss2 = 1'b1;
		spi_di = 1'b0;
		ps2_kbd_clk = 1'b1;
		ps2_kbd_data = 1'b1;
		audio1 = '0;
		audio2 = '0;
		repeat (2) @(posedge clk_24);
		#1;
		reset_test();
		status_test();
		joystick_test();
		keyboard_test();
		audio_test();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* verilog/bomber_shell_top.sv */
// Bomber platform shell
`timescale 1ns/1ps
`include "shell_settings.svh"

module bomber_shell_top (
	input  logic clk_24,
	input  logic rst_n,
	input  logic spi_sck,
	input  logic spi_ss2,
	input  logic spi_di,
	output logic spi_do,
	input  logic ps2_kbd_clk,
	input  logic ps2_kbd_data,
	input  audio_pkg::sample_t audio1,
	input  audio_pkg::sample_t audio2,
	output logic audio_l,
	output logic audio_r,
	output logic game_reset_n,
	output logic coin1_n,
	output logic coin2_n,
	output logic start1_n,
	output logic start2_n,
	output logic fire1_n,
	output logic fire2_n,
	output logic slam_n,
	output logic test_n,
	output logic led
);
	import audio_pkg::*;

	localparam int CH = `SHELL_AUDIO_CHANNELS;

	logic [11:0] kbjoy;
	logic [CH-1:0] sample_valid;
	sample_t sample [CH];
	logic [CH-1:0] credit_return;
	logic [CH-1:0] dac_bits;

	host_state_if host_state ();

	user_io_spi u_user_io_spi (
		.clk_24  (clk_24),
		.rst_n   (rst_n),
		.spi_sck (spi_sck),
		.spi_ss2 (spi_ss2),
		.spi_di  (spi_di),
		.spi_do  (spi_do),
		.host    (host_state.tx)
	);

	ps2_keyboard u_ps2_keyboard (
		.clk_24       (clk_24),
		.rst_n        (rst_n),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.kbjoy        (kbjoy)
	);

	control_mapper u_control_mapper (
		.clk_24       (clk_24),
		.rst_n        (rst_n),
		.host         (host_state.rx),
		.kbjoy        (kbjoy),
		.game_reset_n (game_reset_n),
		.coin1_n      (coin1_n),
		.coin2_n      (coin2_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.fire1_n      (fire1_n),
		.fire2_n      (fire2_n),
		.slam_n       (slam_n),
		.test_n       (test_n)
	);

	audio_sample_dispatch u_dispatch (
		.clk_24        (clk_24),
		.rst_n         (rst_n),
		.audio1        (audio1),
		.audio2        (audio2),
		.sample_valid  (sample_valid),
		.sample        (sample),
		.credit_return (credit_return)
	);

	for (genvar i = 0; i < CH; i++) begin : g_dac
		sigma_delta_dac u_dac (
			.clk_24        (clk_24),
			.rst_n         (rst_n),
			.sample_valid  (sample_valid[i]),
			.sample        (sample[i]),
			.credit_return (credit_return[i]),
			.dac_out       (dac_bits[i])
		);
	end

	assign audio_l = dac_bits[0];
	assign audio_r = dac_bits[1];
	// no status lamp on this board.
	assign led = 1'b0;

endmodule

/* verilog/sigma_delta_dac.sv */
// Sigma-delta audio DAC
`timescale 1ns/1ps
`include "shell_settings.svh"

module sigma_delta_dac (
	input  logic clk_24,
	input  logic rst_n,
	input  logic sample_valid,
	input  audio_pkg::sample_t sample,
	output logic credit_return,
	output logic dac_out
);
	import audio_pkg::*;

	localparam int DEPTH = `SHELL_DAC_CREDITS;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int PER_W = $clog2(`SHELL_DAC_PERIOD);
	localparam int W = $bits(sample_t);

	sample_t fifo [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	credit_t fill;
	logic [PER_W-1:0] period_cnt;
	logic period_end;
	logic pop;
	sample_t level;
	logic [W-1:0] acc;
	logic [W:0] sum;

	assign period_end = (period_cnt == PER_W'(`SHELL_DAC_PERIOD - 1));
	assign pop = period_end && fill != '0;
	assign sum = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge clk_24) begin
		if (sample_valid)
			fifo[wr_ptr] <= sample;
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			period_cnt <= '0;
			credit_return <= 1'b0;
			level <= '0;
			acc <= '0;
			dac_out <= 1'b0;
		end else begin
			period_cnt <= period_end ? '0 : period_cnt + 1'b1;
			if (sample_valid)
				wr_ptr <= wr_ptr + 1'b1;
			// an empty fifo keeps the last level playing.
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				level <= fifo[rd_ptr];
			end
			credit_return <= pop;
			case ({sample_valid, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;
			endcase
			// carry out of the accumulator is the pin stream.
			acc <= sum[W-1:0];
			dac_out <= sum[W];
		end
	end

endmodule

/* verilog/audio_sample_dispatch.sv */
// Audio sample dispatcher
`timescale 1ns/1ps
`include "shell_settings.svh"

module audio_sample_dispatch (
	input  logic clk_24,
	input  logic rst_n,
	input  audio_pkg::sample_t audio1,
	input  audio_pkg::sample_t audio2,
	output logic [`SHELL_AUDIO_CHANNELS-1:0] sample_valid,
	output audio_pkg::sample_t sample [`SHELL_AUDIO_CHANNELS],
	input  logic [`SHELL_AUDIO_CHANNELS-1:0] credit_return
);
	import audio_pkg::*;

	localparam int CH = `SHELL_AUDIO_CHANNELS;
	localparam int DIV_W = $clog2(`SHELL_SAMPLE_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic tick;
	sample_t audio_in [CH];
	sample_t pending [CH];
	logic [CH-1:0] pending_vld;
	logic [CH-1:0] issue;
	credit_t credit [CH];

	assign audio_in[0] = audio1;
	assign audio_in[1] = audio2;
	assign tick = (div_cnt == DIV_W'(`SHELL_SAMPLE_DIV - 1));

	always_ff @(posedge clk_24) begin
		if (!rst_n)
			div_cnt <= '0;
		else
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
	end

	always_comb begin
		for (int i = 0; i < CH; i++)
			issue[i] = pending_vld[i] && credit[i] != '0;
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			pending_vld <= '0;
			sample_valid <= '0;
			for (int i = 0; i < CH; i++)
				credit[i] <= credit_t'(`SHELL_DAC_CREDITS);
		end else begin
			sample_valid <= issue;
			for (int i = 0; i < CH; i++) begin
				if (tick)
					pending_vld[i] <= 1'b1;
				else if (issue[i])
					pending_vld[i] <= 1'b0;
				case ({issue[i], credit_return[i]})
					2'b10: credit[i] <= credit[i] - 1'b1;
					2'b01: credit[i] <= credit[i] + 1'b1;
					default: ;
				endcase
			end
		end
	end

	// a newer sample overwrites one still waiting for credit.
	always_ff @(posedge clk_24) begin
		for (int i = 0; i < CH; i++) begin
			if (tick)
				pending[i] <= audio_in[i];
			if (issue[i])
				sample[i] <= pending[i];
		end
	end

endmodule

/* verilog/control_mapper.sv */
// Game control mapping
`timescale 1ns/1ps
`include "shell_settings.svh"

module control_mapper (
	input  logic clk_24,
	input  logic rst_n,
	host_state_if.rx host,
	input  host_pkg::kbjoy_t kbjoy,
	output logic game_reset_n,
	output logic coin1_n,
	output logic coin2_n,
	output logic start1_n,
	output logic start2_n,
	output logic fire1_n,
	output logic fire2_n,
	output logic slam_n,
	output logic test_n
);
	import host_pkg::*;

	localparam int CNT_W = $clog2(`SHELL_RESET_STRETCH);

	logic reset_cause;
	logic [CNT_W-1:0] hold_cnt;

	assign reset_cause = host.status[STATUS_POR] | host.status[STATUS_MENU_RST] |
		host.buttons[BUTTON_RESET];

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			hold_cnt <= CNT_W'(`SHELL_RESET_STRETCH - 1);
			game_reset_n <= 1'b0;
			coin1_n <= 1'b1;
			coin2_n <= 1'b1;
			start1_n <= 1'b1;
			start2_n <= 1'b1;
			fire1_n <= 1'b1;
			fire2_n <= 1'b1;
			slam_n <= 1'b1;
			test_n <= 1'b1;
		end else begin
			// hold the game in reset until the counter runs out.
			if (reset_cause) begin
				hold_cnt <= CNT_W'(`SHELL_RESET_STRETCH - 1);
				game_reset_n <= 1'b0;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
				game_reset_n <= 1'b0;
			end else begin
				game_reset_n <= 1'b1;
			end
			coin1_n <= ~kbjoy[KEY_COIN];
			coin2_n <= ~kbjoy[KEY_COIN];
			start1_n <= ~kbjoy[KEY_START1];
			start2_n <= ~kbjoy[KEY_START2];
			fire1_n <= ~(host.joy0[JOY_FIRE] | kbjoy[KEY_SPACE]);
			if (host.update) begin
				fire2_n <= ~host.joy1[JOY_FIRE];
				slam_n <= ~host.status[STATUS_SLAM];
				test_n <= ~host.status[STATUS_TEST];
			end
		end
	end

endmodule

/* verilog/ps2_keyboard.sv */
// PS/2 keyboard decoder
`timescale 1ns/1ps

module ps2_keyboard (
	input  logic clk_24,
	input  logic rst_n,
	input  logic ps2_kbd_clk,
	input  logic ps2_kbd_data,
	output host_pkg::kbjoy_t kbjoy
);
	import host_pkg::*;

	localparam logic [7:0] CODE_BREAK = 8'hf0;
	localparam logic [7:0] CODE_SPACE = 8'h29;
	localparam logic [7:0] CODE_KEY1 = 8'h16;
	localparam logic [7:0] CODE_KEY2 = 8'h1e;
	localparam logic [7:0] CODE_KEY5 = 8'h2e;

	logic [2:0] clk_q;
	logic [1:0] dat_q;
	logic clk_f;
	logic fall;
	logic [3:0] bit_cnt;
	logic [9:0] frame;
	logic [7:0] code;
	logic frame_ok;
	logic brk;

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			clk_q <= '1;
			dat_q <= '1;
			clk_f <= 1'b1;
		end else begin
			clk_q <= {clk_q[1:0], ps2_kbd_clk};
			dat_q <= {dat_q[0], ps2_kbd_data};
			// level moves only after two equal samples.
			if (clk_q[2] == clk_q[1])
				clk_f <= clk_q[1];
		end
	end

	assign fall = clk_f & ~clk_q[1] & ~clk_q[2];

	// frame holds start, data and parity; the stop bit is still on the pin.
	assign code = frame[8:1];
	assign frame_ok = ~frame[0] & dat_q[1] & (^frame[9:1]);

	always_ff @(posedge clk_24) begin
		if (fall && bit_cnt != 4'd10)
			frame <= {dat_q[1], frame[9:1]};
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			brk <= 1'b0;
			kbjoy <= '0;
		end else if (fall) begin
			if (bit_cnt == 4'd10) begin
				bit_cnt <= '0;
				if (frame_ok) begin
					if (code == CODE_BREAK) begin
						brk <= 1'b1;
					end else begin
						brk <= 1'b0;
						case (code)
							CODE_SPACE: kbjoy[KEY_SPACE] <= ~brk;
							CODE_KEY1: kbjoy[KEY_START1] <= ~brk;
							CODE_KEY2: kbjoy[KEY_START2] <= ~brk;
							CODE_KEY5: kbjoy[KEY_COIN] <= ~brk;
							default: ;
						endcase
					end
				end
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

endmodule

/* verilog/user_io_spi.sv */
// Host SPI command receiver
`timescale 1ns/1ps
`include "shell_settings.svh"

module user_io_spi (
	input  logic clk_24,
	input  logic rst_n,
	input  logic spi_sck,
	input  logic spi_ss2,
	input  logic spi_di,
	output logic spi_do,
	host_state_if.tx host
);
	import host_pkg::*;

	logic [2:0] sck_q;
	logic [2:0] ss_q;
	logic [1:0] di_q;
	logic sck_rise;
	logic sck_fall;
	logic ss_rise;
	logic active;
	logic [2:0] bit_cnt;
	logic [2:0] byte_cnt;
	logic [6:0] rx_sr;
	logic [7:0] rx_byte;
	logic [7:0] cmd;
	logic [7:0] id_sr;
	status_t stage;

	// sck, ss and di share the same two-flop delay so they stay aligned.
	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			sck_q <= '0;
			ss_q <= '1;
			di_q <= '0;
		end else begin
			sck_q <= {sck_q[1:0], spi_sck};
			ss_q <= {ss_q[1:0], spi_ss2};
			di_q <= {di_q[0], spi_di};
		end
	end

	assign sck_rise = sck_q[1] & ~sck_q[2];
	assign sck_fall = ~sck_q[1] & sck_q[2];
	assign ss_rise = ss_q[1] & ~ss_q[2];
	assign active = ~ss_q[1];
	assign rx_byte = {rx_sr, di_q[1]};

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			byte_cnt <= '0;
			cmd <= '0;
			spi_do <= 1'b0;
			id_sr <= `SHELL_CORE_ID;
		end else if (!active) begin
			bit_cnt <= '0;
			byte_cnt <= '0;
			spi_do <= 1'b0;
			id_sr <= `SHELL_CORE_ID;
		end else begin
			// core id goes out only while the command byte is shifted in.
			spi_do <= (byte_cnt == 3'd0) ? id_sr[7] : 1'b0;
			if (sck_fall && byte_cnt == 3'd0)
				id_sr <= {id_sr[6:0], 1'b0};
			if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					if (byte_cnt == 3'd0)
						cmd <= rx_byte;
					if (byte_cnt != 3'd7)
						byte_cnt <= byte_cnt + 3'd1;
				end
			end
		end
	end

	// data bytes land little endian in the staging word.
	always_ff @(posedge clk_24) begin
		if (active && sck_rise) begin
			rx_sr <= rx_byte[6:0];
			if (bit_cnt == 3'd7) begin
				case (byte_cnt)
					3'd1: stage[7:0] <= rx_byte;
					3'd2: stage[15:8] <= rx_byte;
					3'd3: stage[23:16] <= rx_byte;
					3'd4: stage[31:24] <= rx_byte;
					default: ;
				endcase
			end
		end
	end

	// commit when the host releases ss2.
	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			host.status <= '0;
			host.buttons <= '0;
			host.joy0 <= '0;
			host.joy1 <= '0;
			host.update <= 1'b0;
		end else begin
			host.update <= 1'b0;
			if (ss_rise && byte_cnt >= 3'd2) begin
				case (cmd)
					`SHELL_CMD_BUTTONS: begin
						host.buttons <= stage[1:0];
						host.update <= 1'b1;
					end
					`SHELL_CMD_JOY0: begin
						host.joy0 <= stage[7:0];
						host.update <= 1'b1;
					end
					`SHELL_CMD_JOY1: begin
						host.joy1 <= stage[7:0];
						host.update <= 1'b1;
					end
					`SHELL_CMD_STATUS: begin
						if (byte_cnt >= 3'd5) begin
							host.status <= stage;
							host.update <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* verilog/host_state_if.sv */
// Decoded host state link
`timescale 1ns/1ps

interface host_state_if;
	import host_pkg::*;

	status_t status;
	buttons_t buttons;
	joy_t joy0;
	joy_t joy1;
	// high for one cycle when a register is written.
	logic update;

	modport tx (output status, output buttons, output joy0, output joy1, output update);
	modport rx (input status, input buttons, input joy0, input joy1, input update);

endinterface

/* verilog/audio_pkg.sv */
// Audio types
`include "shell_settings.svh"

package audio_pkg;

	// unsigned game sample.
	typedef logic [`SHELL_AUDIO_WIDTH-1:0] sample_t;

	// covers 0 up to the dac fifo depth.
	typedef logic [2:0] credit_t;

endpackage

/* verilog/host_pkg.sv */
// Host side types
package host_pkg;

	typedef logic [31:0] status_t;
	typedef logic [1:0] buttons_t;
	typedef logic [7:0] joy_t;
	typedef logic [11:0] kbjoy_t;

	// status word bits.
	localparam int STATUS_POR = 0;
	localparam int STATUS_TEST = 1;
	localparam int STATUS_SLAM = 2;
	localparam int STATUS_MENU_RST = 6;

	// button and joystick bits.
	localparam int BUTTON_RESET = 1;
	localparam int JOY_FIRE = 4;

	// key word bits.
	localparam int KEY_SPACE = 4;
	localparam int KEY_START1 = 5;
	localparam int KEY_START2 = 6;
	localparam int KEY_COIN = 7;

endpackage

/* verilog/shell_settings.svh */
// Shell build settings
`ifndef SHELL_SETTINGS_SVH
`define SHELL_SETTINGS_SVH

// audio path.
`define SHELL_AUDIO_WIDTH 7
`define SHELL_AUDIO_CHANNELS 2
`define SHELL_DAC_CREDITS 4
`define SHELL_SAMPLE_DIV 256
`define SHELL_DAC_PERIOD 256

// game reset hold time in clk_24 cycles.
`define SHELL_RESET_STRETCH 16

// host spi command bytes.
`define SHELL_CMD_BUTTONS 8'h01
`define SHELL_CMD_JOY0 8'h02
`define SHELL_CMD_JOY1 8'h03
`define SHELL_CMD_STATUS 8'h1e
`define SHELL_CORE_ID 8'ha4

`endif
